/* run_sim.sh */
#!/usr/bin/env bash
# Builds the arcade control wrapper testbench with Verilator and runs it.
# The run passes only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module emu_tb \
  -f verilog.f -o emu_tb_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/emu_tb_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -qx "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* src/core_reset_sync.sv */
// Core reset generator
// Merges board reset, host reset bit and user button into one core reset
`timescale 1ns/1ps

module core_reset_sync (
  input  logic clk_sys,
  input  logic RESET,
  input  logic status_reset,
  input  logic user_button,
  output logic core_reset
);

  logic       cause;
  logic [1:0] sync_q;

  // Soft causes, both already in the clk_sys domain
  assign cause = status_reset | user_button;

  ////////////////////////////////////////////////////////////
  // Two-flop release chain
  ////////////////////////////////////////////////////////////

  // RESET asserts at once, soft causes on the next edge
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      sync_q <= 2'b11;
    end else if (cause) begin
      sync_q <= 2'b11;
    end else begin
      // Shift zeros in, release after two clean edges
      sync_q <= {sync_q[0], 1'b0};
    end
  end

  assign core_reset = sync_q[1];

endmodule

/* src/emu_macros.svh */
// Arcade control wrapper constants
// Bus widths, host register map, PS/2 scan codes and the PLL reset stretch
`ifndef EMU_MACROS_SVH
`define EMU_MACROS_SVH

// Host status word and joystick words
`define EMU_STATUS_W 32
`define EMU_JOY_W 32

// PS/2 event layout
`define EMU_PS2_W 11
`define EMU_PS2_TOGGLE 10
`define EMU_PS2_PRESSED 9

// Lock loss stretch, in clk_sys cycles
`define EMU_LOCK_RESET_CYCLES 256

// APB register map
`define EMU_ADDR_W 8
`define EMU_ADDR_STATUS 8'h00
`define EMU_ADDR_ID 8'h04
// ASCII "CAVE"
`define EMU_CORE_ID 32'h4341_5645

// Set 2 scan codes, extended prefix stripped
`define EMU_KEY_UP 8'h75
`define EMU_KEY_DOWN 8'h72
`define EMU_KEY_LEFT 8'h6b
`define EMU_KEY_RIGHT 8'h74
`define EMU_KEY_CTRL 8'h14
`define EMU_KEY_ALT 8'h11
`define EMU_KEY_SHIFT 8'h12
`define EMU_KEY_SPACE 8'h29
`define EMU_KEY_1 8'h16
`define EMU_KEY_2 8'h1e
`define EMU_KEY_5 8'h2e
`define EMU_KEY_6 8'h36
`define EMU_KEY_A 8'h1c
`define EMU_KEY_S 8'h1b
`define EMU_KEY_Q 8'h15
`define EMU_KEY_W 8'h1d
`define EMU_KEY_R 8'h2d
`define EMU_KEY_F 8'h2b
`define EMU_KEY_D 8'h23
`define EMU_KEY_G 8'h34
`define EMU_KEY_P 8'h4d

`endif

/* src/emu_pkg.sv */
// Shared types for the arcade control wrapper
// Player controls, core options, video settings and the APB bus
`include "emu_macros.svh"

package emu_pkg;

  // Scan codes the input decoder reacts to
  typedef enum logic [7:0] {
    KEY_UP    = `EMU_KEY_UP,
    KEY_DOWN  = `EMU_KEY_DOWN,
    KEY_LEFT  = `EMU_KEY_LEFT,
    KEY_RIGHT = `EMU_KEY_RIGHT,
    KEY_CTRL  = `EMU_KEY_CTRL,
    KEY_ALT   = `EMU_KEY_ALT,
    KEY_SHIFT = `EMU_KEY_SHIFT,
    KEY_SPACE = `EMU_KEY_SPACE,
    KEY_1     = `EMU_KEY_1,
    KEY_2     = `EMU_KEY_2,
    KEY_5     = `EMU_KEY_5,
    KEY_6     = `EMU_KEY_6,
    KEY_A     = `EMU_KEY_A,
    KEY_S     = `EMU_KEY_S,
    KEY_Q     = `EMU_KEY_Q,
    KEY_W     = `EMU_KEY_W,
    KEY_R     = `EMU_KEY_R,
    KEY_F     = `EMU_KEY_F,
    KEY_D     = `EMU_KEY_D,
    KEY_G     = `EMU_KEY_G,
    KEY_P     = `EMU_KEY_P
  } key_code_e;

  // Game board select, status bits 21..18
  typedef enum logic [3:0] {
    PCB_DFEVERON   = 4'd0,
    PCB_DODONPACHI = 4'd1,
    PCB_DONPACHI   = 4'd2,
    PCB_ESPRADE    = 4'd3,
    PCB_UOPOKO     = 4'd4,
    PCB_GUWANGE    = 4'd5,
    PCB_GAIA       = 4'd6,
    PCB_HOTDOGST   = 4'd7
  } pcb_e;

  // One player's controls, buttons[0] is button 1
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] buttons;
    logic       start;
    logic       coin;
    logic       pause;
  } player_t;

  typedef struct packed {
    logic [3:0] offset_x;
    logic [3:0] offset_y;
    logic       rotate;
    logic       flip;
    logic       compat;
    logic       service;
    logic       sprite_en;
    logic [2:0] layer_en;
    pcb_e       pcb;
  } core_opts_t;

  // Aspect ratio and scaler settings, padded to a word
  typedef struct packed {
    logic [11:0] arx;
    logic [11:0] ary;
    logic [1:0]  scanlines;
    logic        scandoubler;
    logic        hq2x;
    logic [3:0]  spare;
  } video_cfg_t;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`EMU_ADDR_W-1:0]    paddr;
    logic [`EMU_STATUS_W-1:0]  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`EMU_STATUS_W-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
  } apb_rsp_t;

endpackage

/* src/emu_top.sv */
// Arcade control wrapper top level
// Host register, player inputs, video settings and reset generation
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_top (
  input  logic                  clk_sys,
  input  logic                  RESET,
  // Host bus
  input  emu_pkg::apb_req_t     apb_req,
  output emu_pkg::apb_rsp_t     apb_rsp,
  // Clocking and reset
  input  logic                  pll_locked,
  output logic                  pll_reset,
  input  logic                  user_button,
  input  logic                  force_scandoubler,
  // Controls
  input  logic [`EMU_PS2_W-1:0] ps2_key,
  input  logic [`EMU_JOY_W-1:0] joystick_0,
  input  logic [`EMU_JOY_W-1:0] joystick_1,
  output emu_pkg::player_t      player_0,
  output emu_pkg::player_t      player_1,
  // To the core and scaler
  output emu_pkg::core_opts_t   opts,
  output emu_pkg::video_cfg_t   video,
  output logic                  new_vmode,
  output logic                  core_reset
);

  logic [`EMU_STATUS_W-1:0] status;

  lock_reset_gen u_lock (
    .clk_sys(clk_sys), .RESET(RESET), .pll_locked(pll_locked), .pll_reset(pll_reset)
  );

  // Status bit 0 is the menu reset entry
  core_reset_sync u_core_rst (
    .clk_sys(clk_sys), .RESET(RESET), .status_reset(status[0]),
    .user_button(user_button), .core_reset(core_reset)
  );

  player_inputs u_players (
    .clk_sys(clk_sys), .RESET(RESET), .ps2_key(ps2_key),
    .joystick_0(joystick_0), .joystick_1(joystick_1),
    .player_0(player_0), .player_1(player_1)
  );

  status_regs u_status (
    .clk_sys(clk_sys), .RESET(RESET), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .status(status), .opts(opts)
  );

  video_config u_video (
    .clk_sys(clk_sys), .RESET(RESET), .status(status),
    .force_scandoubler(force_scandoubler), .video(video), .new_vmode(new_vmode)
  );

endmodule

/* src/lock_reset_gen.sv */
// PLL lock supervisor
// Fires a fixed-length PLL reset pulse whenever lock drops
`timescale 1ns/1ps
`include "emu_macros.svh"

module lock_reset_gen (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic pll_reset
);

  // Counter must hold the full stretch value
  localparam int unsigned CNT_W = $clog2(`EMU_LOCK_RESET_CYCLES + 1);
  localparam logic [CNT_W-1:0] STRETCH = CNT_W'(`EMU_LOCK_RESET_CYCLES);

  logic             lock_q;
  logic [CNT_W-1:0] cnt;
  logic             lock_lost;

  // Falling edge of lock, ignored while a pulse is running
  assign lock_lost = lock_q && !pll_locked && (cnt == '0);

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      lock_q <= 1'b0;
      cnt    <= '0;
    end else begin
      lock_q <= pll_locked;
      if (lock_lost) begin
        cnt <= STRETCH;
      end else if (cnt != '0) begin
        cnt <= cnt - CNT_W'(1);
      end
    end
  end

  // High for every nonzero count, 256 down to 1
  assign pll_reset = (cnt != '0);

  // Pulse ends exactly after the stretch length
  a_pulse_len: assert property (@(posedge clk_sys) disable iff (RESET)
    $rose(pll_reset) |-> ##(`EMU_LOCK_RESET_CYCLES) !pll_reset);

endmodule

/* src/player_inputs.sv */
// Player input decoder
// Tracks held PS/2 keys and merges them with the two joystick words
`timescale 1ns/1ps
`include "emu_macros.svh"

module player_inputs (
  input  logic                  clk_sys,
  input  logic                  RESET,
  input  logic [`EMU_PS2_W-1:0] ps2_key,
  input  logic [`EMU_JOY_W-1:0] joystick_0,
  input  logic [`EMU_JOY_W-1:0] joystick_1,
  output emu_pkg::player_t      player_0,
  output emu_pkg::player_t      player_1
);

  // One bit per mapped key
  typedef struct packed {
    logic up, down, left, right;
    logic ctrl, alt, shift, space;
    logic k1, k2, k5, k6;
    logic a, s, q, w;
    logic r, f, d, g, p;
  } keys_t;

  keys_t            keys_q;
  logic             toggle_q;
  logic             key_event;
  logic             pressed;
  logic [7:0]       code;
  emu_pkg::player_t key_p0;
  emu_pkg::player_t key_p1;

  assign key_event = toggle_q != ps2_key[`EMU_PS2_TOGGLE];
  assign pressed   = ps2_key[`EMU_PS2_PRESSED];
  assign code      = ps2_key[7:0];

  ////////////////////////////////////////////////////////////
  // Key state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_q <= 1'b0;
      keys_q   <= '0;
    end else begin
      toggle_q <= ps2_key[`EMU_PS2_TOGGLE];
      if (key_event) begin
        case (code)
          emu_pkg::KEY_UP:    keys_q.up    <= pressed;
          emu_pkg::KEY_DOWN:  keys_q.down  <= pressed;
          emu_pkg::KEY_LEFT:  keys_q.left  <= pressed;
          emu_pkg::KEY_RIGHT: keys_q.right <= pressed;
          emu_pkg::KEY_CTRL:  keys_q.ctrl  <= pressed;
          emu_pkg::KEY_ALT:   keys_q.alt   <= pressed;
          emu_pkg::KEY_SHIFT: keys_q.shift <= pressed;
          emu_pkg::KEY_SPACE: keys_q.space <= pressed;
          emu_pkg::KEY_1:     keys_q.k1    <= pressed;
          emu_pkg::KEY_2:     keys_q.k2    <= pressed;
          emu_pkg::KEY_5:     keys_q.k5    <= pressed;
          emu_pkg::KEY_6:     keys_q.k6    <= pressed;
          emu_pkg::KEY_A:     keys_q.a     <= pressed;
          emu_pkg::KEY_S:     keys_q.s     <= pressed;
          emu_pkg::KEY_Q:     keys_q.q     <= pressed;
          emu_pkg::KEY_W:     keys_q.w     <= pressed;
          emu_pkg::KEY_R:     keys_q.r     <= pressed;
          emu_pkg::KEY_F:     keys_q.f     <= pressed;
          emu_pkg::KEY_D:     keys_q.d     <= pressed;
          emu_pkg::KEY_G:     keys_q.g     <= pressed;
          emu_pkg::KEY_P:     keys_q.p     <= pressed;
          // Anything else is not ours
          default: ;
        endcase
      end
    end
  end

  // Keyboard view of each player, player 2 pause is joystick only
  assign key_p0 = '{up: keys_q.up, down: keys_q.down, left: keys_q.left, right: keys_q.right,
                    buttons: {keys_q.shift, keys_q.space, keys_q.alt, keys_q.ctrl},
                    start: keys_q.k1, coin: keys_q.k5, pause: keys_q.p};
  assign key_p1 = '{up: keys_q.r, down: keys_q.f, left: keys_q.d, right: keys_q.g,
                    buttons: {keys_q.w, keys_q.q, keys_q.s, keys_q.a},
                    start: keys_q.k2, coin: keys_q.k6, pause: 1'b0};

  // Joystick bits 0..3 right/left/down/up, 4..7 buttons, 8..10 start/coin/pause
  function automatic emu_pkg::player_t merge(input emu_pkg::player_t k,
                                             input logic [`EMU_JOY_W-1:0] joy);
    emu_pkg::player_t p;
    p.up      = k.up    | joy[3];
    p.down    = k.down  | joy[2];
    p.left    = k.left  | joy[1];
    p.right   = k.right | joy[0];
    p.buttons = k.buttons | joy[7:4];
    p.start   = k.start | joy[8];
    p.coin    = k.coin  | joy[9];
    p.pause   = k.pause | joy[10];
    return p;
  endfunction

  // Registered outputs
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      player_0 <= '0;
      player_1 <= '0;
    end else begin
      player_0 <= merge(key_p0, joystick_0);
      player_1 <= merge(key_p1, joystick_1);
    end
  end

endmodule

/* src/status_regs.sv */
// Host status register
// Zero-wait APB slave holding the option word, decoded into core options
`timescale 1ns/1ps
`include "emu_macros.svh"

module status_regs (
  input  logic                     clk_sys,
  input  logic                     RESET,
  input  emu_pkg::apb_req_t        apb_req,
  output emu_pkg::apb_rsp_t        apb_rsp,
  output logic [`EMU_STATUS_W-1:0] status,
  output emu_pkg::core_opts_t      opts
);

  logic [`EMU_STATUS_W-1:0] status_q;
  logic                     access;
  logic                     hit_status;
  logic                     hit_id;
  logic                     bad_req;

  ////////////////////////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////////////////////////

  assign access     = apb_req.psel && apb_req.penable;
  assign hit_status = apb_req.paddr == `EMU_ADDR_STATUS;
  assign hit_id     = apb_req.paddr == `EMU_ADDR_ID;
  // Unmapped address, or ID written
  assign bad_req    = !(hit_status || hit_id) || (apb_req.pwrite && hit_id);

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      status_q <= '0;
    end else if (access && apb_req.pwrite && hit_status) begin
      status_q <= apb_req.pwdata;
    end
  end

  // Never stalls
  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && bad_req;
    apb_rsp.prdata  = '0;
    if (apb_req.psel && !apb_req.pwrite) begin
      if (hit_status) begin
        apb_rsp.prdata = status_q;
      end else if (hit_id) begin
        apb_rsp.prdata = `EMU_CORE_ID;
      end
    end
  end

  assign status = status_q;

  ////////////////////////////////////////////////////////////
  // Option decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    opts.offset_x  = status_q[27:24];
    opts.offset_y  = status_q[31:28];
    opts.rotate    = status_q[3];
    opts.flip      = status_q[4];
    opts.compat    = status_q[8];
    opts.service   = status_q[9];
    // Menu bits mean "off", core wants enables
    opts.sprite_en = ~status_q[10];
    opts.layer_en  = ~status_q[13:11];
    opts.pcb       = emu_pkg::pcb_e'(status_q[21:18]);
  end

  // Host must not raise penable without psel
  a_pen_psel: assert property (@(posedge clk_sys) disable iff (RESET)
    apb_req.penable |-> apb_req.psel);

  // Error only in an access phase that followed a setup phase
  a_err_access: assert property (@(posedge clk_sys) disable iff (RESET)
    apb_rsp.pslverr |-> access && $past(apb_req.psel && !apb_req.penable));

endmodule

/* src/video_config.sv */
// Video settings decode
// Aspect ratio, scanline and scaler choices from the status word,
// plus a toggle that tells the host the refresh mode changed
`timescale 1ns/1ps
`include "emu_macros.svh"

module video_config (
  input  logic                     clk_sys,
  input  logic                     RESET,
  input  logic [`EMU_STATUS_W-1:0] status,
  input  logic                     force_scandoubler,
  output emu_pkg::video_cfg_t      video,
  output logic                     new_vmode
);

  logic [1:0] aspect;
  logic       rotate;
  logic [2:0] fx;
  logic [2:0] sl;
  logic       vmode_q;

  assign aspect = status[2:1];
  assign rotate = status[3];
  // 0 none, 1 HQ2x, 2..4 CRT levels
  assign fx     = status[7:5];
  assign sl     = (fx != 3'd0) ? fx - 3'd1 : 3'd0;

  always_comb begin
    video = '0;
    if (aspect == 2'd0) begin
      // Native 4:3, turned on its side when rotated
      video.arx = rotate ? 12'd3 : 12'd4;
      video.ary = rotate ? 12'd4 : 12'd3;
    end else begin
      // Fullscreen and custom ratios, ary of 0 selects them
      video.arx = {10'd0, aspect - 2'd1};
      video.ary = 12'd0;
    end
    video.scanlines   = sl[1:0];
    video.scandoubler = (fx != 3'd0) || force_scandoubler;
    video.hq2x        = fx == 3'd1;
  end

  ////////////////////////////////////////////////////////////
  // Refresh mode change
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      vmode_q   <= 1'b0;
      new_vmode <= 1'b0;
    end else if (status[8] != vmode_q) begin
      // One flip per change of bit 8
      vmode_q   <= status[8];
      new_vmode <= ~new_vmode;
    end
  end

endmodule

/* tests/emu_tb.sv */
// Testbench for the arcade control wrapper
// Drives APB, PS/2, joystick, lock and button inputs into emu_top
// and checks options, video settings, players and resets
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_tb;

  // Rough test lengths in clock cycles
  // Watchdog allows twice their sum
  localparam int RESET_CYCLES = 20;
  localparam int APB_CYCLES   = 120;
  localparam int OPTS_CYCLES  = 40;
  localparam int VIDEO_CYCLES = 128 * 5 + 40;
  localparam int KEY_CYCLES   = 21 * 2 * 4 + 80;
  localparam int LOCK_CYCLES  = 2 * `EMU_LOCK_RESET_CYCLES + 60;
  localparam int CORE_CYCLES  = 40;
  localparam int WATCHDOG_NS  = 2 * 10 * (RESET_CYCLES + APB_CYCLES + OPTS_CYCLES +
                                VIDEO_CYCLES + KEY_CYCLES + LOCK_CYCLES + CORE_CYCLES);

  logic                  clk_sys;
  logic                  RESET;
  emu_pkg::apb_req_t     apb_req;
  emu_pkg::apb_rsp_t     apb_rsp;
  logic                  pll_locked;
  logic                  pll_reset;
  logic                  user_button;
  logic                  force_scandoubler;
  logic [`EMU_PS2_W-1:0] ps2_key;
  logic [`EMU_JOY_W-1:0] joystick_0;
  logic [`EMU_JOY_W-1:0] joystick_1;
  emu_pkg::player_t      player_0;
  emu_pkg::player_t      player_1;
  emu_pkg::core_opts_t   opts;
  emu_pkg::video_cfg_t   video;
  logic                  new_vmode;
  logic                  core_reset;

  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  string       test_name;
  logic [31:0] lfsr;

  emu_top dut0 (
    .clk_sys(clk_sys), .RESET(RESET), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .pll_locked(pll_locked), .pll_reset(pll_reset), .user_button(user_button),
    .force_scandoubler(force_scandoubler), .ps2_key(ps2_key),
    .joystick_0(joystick_0), .joystick_1(joystick_1),
    .player_0(player_0), .player_1(player_1), .opts(opts), .video(video),
    .new_vmode(new_vmode), .core_reset(core_reset)
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // Board reset forces the core reset
  a_core_in_reset: assert property (@(posedge clk_sys) RESET |-> core_reset)
    else begin
      errors = errors + 1;
      $display("core_reset was low while RESET was high");
    end

  // Zero-wait slave
  a_no_wait: assert property (@(posedge clk_sys) disable iff (RESET) apb_rsp.pready)
    else begin
      errors = errors + 1;
      $display("APB pready dropped, the slave inserted a wait state");
    end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    tests = tests + 1;
    $display("Test %s: %s", test_name, (errors == err_mark) ? "PASS" : "FAIL");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks = checks + 1;
    assert (expected === actual) else begin
      errors = errors + 1;
      $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // Setup phase and access phase, sampled in the middle of access
  task automatic apb_xfer(input logic write, input logic [7:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(posedge clk_sys);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk_sys);
    apb_req.penable <= 1'b1;
    @(negedge clk_sys);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk_sys);
    apb_req <= '0;
  endtask

  task automatic write_status(input logic [31:0] value);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, `EMU_ADDR_STATUS, value, rd, err);
    check_value("status write error", 0, 32'(err));
  endtask

  // New toggle value then two edges to the player outputs
  task automatic send_key(input logic [7:0] code, input logic pressed);
    @(posedge clk_sys);
    ps2_key <= {~ps2_key[`EMU_PS2_TOGGLE], pressed, 1'b0, code};
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
  endtask

  // Bit of a key in {player_1, player_0}
  // Field order up down left right, buttons 4..1, start coin pause
  function automatic int key_bit(input logic [7:0] code);
    case (code)
      `EMU_KEY_UP:    return 10;
      `EMU_KEY_DOWN:  return 9;
      `EMU_KEY_LEFT:  return 8;
      `EMU_KEY_RIGHT: return 7;
      `EMU_KEY_CTRL:  return 3;
      `EMU_KEY_ALT:   return 4;
      `EMU_KEY_SPACE: return 5;
      `EMU_KEY_SHIFT: return 6;
      `EMU_KEY_1:     return 2;
      `EMU_KEY_5:     return 1;
      `EMU_KEY_P:     return 0;
      `EMU_KEY_R:     return 21;
      `EMU_KEY_F:     return 20;
      `EMU_KEY_D:     return 19;
      `EMU_KEY_G:     return 18;
      `EMU_KEY_A:     return 14;
      `EMU_KEY_S:     return 15;
      `EMU_KEY_Q:     return 16;
      `EMU_KEY_W:     return 17;
      `EMU_KEY_2:     return 13;
      `EMU_KEY_6:     return 12;
      default:        return -1;
    endcase
  endfunction

  // Joystick 0..3 right left down up, 4..7 buttons, 8 start, 9 coin, 10 pause
  function automatic logic [10:0] joy_expect(input logic [31:0] j);
    return {j[3], j[2], j[1], j[0], j[7:4], j[8], j[9], j[10]};
  endfunction

  // Expected {arx, ary, scanlines, scandoubler, hq2x}
  function automatic logic [27:0] video_expect(input logic [1:0] asp, input logic rot,
                                               input logic [2:0] fx, input logic fsd);
    logic [11:0] arx;
    logic [11:0] ary;
    logic [1:0]  sl;
    if (asp == 2'd0) begin
      arx = rot ? 12'd3 : 12'd4;
      ary = rot ? 12'd4 : 12'd3;
    end else begin
      arx = 12'(asp) - 12'd1;
      ary = 12'd0;
    end
    sl = (fx == 3'd0) ? 2'd0 : 2'(fx - 3'd1);
    return {arx, ary, sl, (fx != 3'd0) || fsd, fx == 3'd1};
  endfunction

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    logic [31:0] rd;
    logic        err;
    start_test("reset_values");
    @(negedge clk_sys);
    check_value("pll_reset", 0, 32'(pll_reset));
    check_value("new_vmode", 0, 32'(new_vmode));
    check_value("players", 0, 32'({player_1, player_0}));
    check_value("pslverr", 0, 32'(apb_rsp.pslverr));
    apb_xfer(1'b0, `EMU_ADDR_STATUS, 32'd0, rd, err);
    check_value("status", 0, rd);
    finish_test();
  endtask

  task automatic apb_register_test();
    logic [31:0] w;
    logic [31:0] rd;
    logic        err;
    start_test("apb_regs");
    w = '0;
    repeat (8) begin
      w = next_bits(32);
      write_status(w);
      apb_xfer(1'b0, `EMU_ADDR_STATUS, 32'd0, rd, err);
      check_value("status read-back", w, rd);
      check_value("status read error", 0, 32'(err));
    end
    apb_xfer(1'b0, `EMU_ADDR_ID, 32'd0, rd, err);
    check_value("id read", `EMU_CORE_ID, rd);
    check_value("id read error", 0, 32'(err));
    apb_xfer(1'b1, `EMU_ADDR_ID, ~w, rd, err);
    check_value("id write error", 1, 32'(err));
    apb_xfer(1'b1, 8'h08, ~w, rd, err);
    check_value("unmapped write error", 1, 32'(err));
    apb_xfer(1'b0, 8'h0c, 32'd0, rd, err);
    check_value("unmapped read error", 1, 32'(err));
    // Rejected writes leave the word alone
    apb_xfer(1'b0, `EMU_ADDR_STATUS, 32'd0, rd, err);
    check_value("status after errors", w, rd);
    write_status(32'd0);
    finish_test();
  endtask

  task automatic option_decode_test();
    logic [31:0] w;
    logic [19:0] exp;
    start_test("opts_decode");
    repeat (8) begin
      w = next_bits(32);
      write_status(w);
      @(negedge clk_sys);
      // Sprite and layer bits are disables in the word
      exp = {w[27:24], w[31:28], w[3], w[4], w[8], w[9], ~w[10], ~w[13:11], w[21:18]};
      check_value("opts", 32'(exp), 32'(opts));
    end
    write_status(32'd0);
    finish_test();
  endtask

  task automatic video_decode_test();
    logic [1:0] asp;
    logic [2:0] fx;
    logic       rot;
    logic       fsd;
    logic       nv;
    start_test("video_config");
    for (int i = 0; i < 128; i++) begin
      asp = i[1:0];
      rot = i[2];
      fsd = i[3];
      fx  = i[6:4];
      @(posedge clk_sys);
      force_scandoubler <= fsd;
      write_status({24'd0, fx, 1'b0, rot, asp, 1'b0});
      @(negedge clk_sys);
      // Spare padding stays zero
      check_value("video", {video_expect(asp, rot, fx, fsd), 4'd0}, 32'(video));
    end
    @(posedge clk_sys);
    force_scandoubler <= 1'b0;
    // Mode toggle: bit 8 set, other bits moved, bit 8 cleared
    nv = new_vmode;
    write_status(32'h0000_0100);
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("vmode set", 32'(!nv), 32'(new_vmode));
    write_status(32'h0000_1100);
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("vmode steady", 32'(!nv), 32'(new_vmode));
    write_status(32'd0);
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("vmode clear", 32'(nv), 32'(new_vmode));
    finish_test();
  endtask

  task automatic key_input_test();
    emu_pkg::key_code_e k;
    logic [31:0]        j0;
    logic [31:0]        j1;
    start_test("player_inputs");
    k = k.first();
    for (int i = 0; i < k.num(); i++) begin
      send_key(k, 1'b1);
      check_value("key press", 32'(22'd1 << key_bit(k)), 32'({player_1, player_0}));
      send_key(k, 1'b0);
      check_value("key release", 0, 32'({player_1, player_0}));
      k = k.next();
    end
    // Enter, not mapped
    send_key(8'h5a, 1'b1);
    check_value("unmapped key", 0, 32'({player_1, player_0}));
    send_key(8'h5a, 1'b0);
    // Toggle bit unchanged, no event
    @(posedge clk_sys);
    ps2_key <= {ps2_key[`EMU_PS2_TOGGLE], 1'b1, 1'b0, `EMU_KEY_UP};
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("stale event", 0, 32'({player_1, player_0}));
    // Random sticks with player 1 pause held on the keyboard
    send_key(`EMU_KEY_P, 1'b1);
    repeat (8) begin
      j0 = next_bits(32);
      j1 = next_bits(32);
      @(posedge clk_sys);
      joystick_0 <= j0;
      joystick_1 <= j1;
      @(posedge clk_sys);
      @(negedge clk_sys);
      check_value("joystick 0", 32'(joy_expect(j0) | 11'd1), 32'(player_0));
      check_value("joystick 1", 32'(joy_expect(j1)), 32'(player_1));
    end
    @(posedge clk_sys);
    joystick_0 <= '0;
    joystick_1 <= '0;
    send_key(`EMU_KEY_P, 1'b0);
    finish_test();
  endtask

  task automatic lock_loss_test();
    int high;
    start_test("lock_loss");
    high = 0;
    repeat (20) begin
      @(negedge clk_sys);
      if (pll_reset) begin
        high++;
      end
    end
    check_value("steady lock", 0, 32'(high));
    @(posedge clk_sys);
    pll_locked <= 1'b0;
    // Lock stays low so only one pulse fits in the window
    high = 0;
    repeat (2 * `EMU_LOCK_RESET_CYCLES) begin
      @(negedge clk_sys);
      if (pll_reset) begin
        high++;
      end
    end
    check_value("pulse length", `EMU_LOCK_RESET_CYCLES, 32'(high));
    @(posedge clk_sys);
    pll_locked <= 1'b1;
    finish_test();
  endtask

  task automatic core_reset_test();
    start_test("core_reset");
    @(negedge clk_sys);
    check_value("idle", 0, 32'(core_reset));
    @(posedge clk_sys);
    user_button <= 1'b1;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("button assert", 1, 32'(core_reset));
    @(posedge clk_sys);
    user_button <= 1'b0;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("button hold", 1, 32'(core_reset));
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("button release", 0, 32'(core_reset));
    // Host reset bit
    write_status(32'd1);
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("status assert", 1, 32'(core_reset));
    write_status(32'd0);
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("status hold", 1, 32'(core_reset));
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_value("status release", 0, 32'(core_reset));
    finish_test();
  endtask

  initial begin
    errors            = 0;
    checks            = 0;
    tests             = 0;
    err_mark          = 0;
    test_name         = "";
    lfsr              = 32'he073;
    RESET             = 1'b1;
    apb_req           = '0;
    pll_locked        = 1'b1;
    user_button       = 1'b0;
    force_scandoubler = 1'b0;
    ps2_key           = '0;
    joystick_0        = '0;
    joystick_1        = '0;
    repeat (4) @(posedge clk_sys);
    RESET <= 1'b0;
    reset_state_test();
    apb_register_test();
    option_decode_test();
    video_decode_test();
    key_input_test();
    lock_loss_test();
    core_reset_test();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/emu_pkg.sv
src/lock_reset_gen.sv
src/core_reset_sync.sv
src/player_inputs.sv
src/status_regs.sv
src/video_config.sv
src/emu_top.sv
tests/emu_tb.sv
